// ==== Makefile ====
# Verilator build and run of the cpu bus testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_bus_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

# build, run, and pass only if the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cpu_bus_properties.sv ====
// ---------------------------
// cpu bus properties
// grant locking and acknowledge rules on the arbiter
// ---------------------------

module cpu_bus_properties (
	input logic                    clk,
	input logic                    reset,
	input cpu_bus_pkg::arb_state_t arb_state_i,
	input logic                    inst_stb_i,
	input logic                    data_stb_i,
	input logic                    bus_stb_i,
	input logic                    bus_ack_i,
	input logic                    inst_ack_i,
	input logic                    data_ack_i
);

	timeunit 1ns;
	timeprecision 100ps;

	import cpu_bus_pkg::*;

	int assert_errors = 0;

	// owner of the bus in this cycle
	// in idle the data strobe decides
	arb_state_t grant_now;

	assign grant_now = (arb_state_i != ARB_IDLE) ? arb_state_i
		: (data_stb_i ? ARB_DATA : ARB_INST);

	// grant holds while an access waits for its ack
	grant_locked: assert property (@(posedge clk) disable iff (reset)
		(bus_stb_i && !bus_ack_i) |=> (grant_now == $past(grant_now)))
	else begin
		$error("grant changed during an outstanding access");
		assert_errors++;
	end

	// at most one master sees the ack, the one holding the grant
	ack_to_granted_master: assert property (@(posedge clk) disable iff (reset)
		!(inst_ack_i && arb_state_i != ARB_INST) && !(data_ack_i && arb_state_i != ARB_DATA))
	else begin
		$error("acknowledge routed to a master without the grant");
		assert_errors++;
	end

	// every ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		(bus_ack_i || inst_ack_i || data_ack_i) |=> !(bus_ack_i || inst_ack_i || data_ack_i))
	else begin
		$error("acknowledge held longer than one cycle");
		assert_errors++;
	end

	ack_to_strobing_master: assert property (@(posedge clk) disable iff (reset)
		!(inst_ack_i && !inst_stb_i) && !(data_ack_i && !data_stb_i))
	else begin
		$error("acknowledge sent to a master that is not strobing");
		assert_errors++;
	end

endmodule

bind bus_arbiter cpu_bus_properties u_arb_props (
	.clk         (clk),
	.reset       (reset),
	.arb_state_i (arb_state),
	.inst_stb_i  (inst_req_i.stb),
	.data_stb_i  (data_req_i.stb),
	.bus_stb_i   (bus_req_o.stb),
	.bus_ack_i   (bus_ack_i),
	.inst_ack_i  (inst_ack_o),
	.data_ack_i  (data_ack_o)
);

// ==== bench/tb_cpu_bus_top.sv ====
// ---------------------------
// cpu bus testbench
// two masters, shadow memory and an ack scoreboard
// ---------------------------

`include "cpu_bus_defs.svh"

module tb_cpu_bus_top;

	timeunit 1ns;
	timeprecision 100ps;

	import cpu_bus_pkg::*;

	localparam int wait_cycles = `BUS_WAIT_CYCLES;
	localparam int mem_words = 1 << `MEM_ADDR_BITS;
	localparam int byte_pairs = 24;
	localparam int mixed_per_port = 100;

	// every transfer the run issues, reset checks excluded
	localparam int total_transfers = 2 + mem_words + 2 * byte_pairs + 2 + 2 * mixed_per_port;
	localparam int cycle_limit = 8 * total_transfers * (wait_cycles + 2);

	logic        clk;
	logic        reset;
	wb_req_t     inst_req;
	wb_req_t     data_req;
	logic [31:0] rd_dat;
	logic        inst_ack;
	logic        data_ack;

	// expected ram contents
	logic [31:0] shadow [mem_words];
	int          cycle_count;

	cpu_bus_top UUT (
		.clk        (clk),
		.reset      (reset),
		.inst_req_i (inst_req),
		.data_req_i (data_req),
		.rd_dat_o   (rd_dat),
		.inst_ack_o (inst_ack),
		.data_ack_o (data_ack)
	);

	// ---------------------------
	// clock and watchdog
	// ---------------------------

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
			if (cycle_count > cycle_limit) begin
				$display("SOME TESTS FAILED");
				$display("timeout: an acknowledge never arrived within %0d cycles", cycle_limit);
				$fatal(1, "run stopped at the cycle limit");
			end
		end
	end

	// ---------------------------
	// helpers
	// ---------------------------

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// merges a write into the shadow memory and returns the word after it
	function automatic logic [31:0] ref_access(input wb_req_t req);
		logic [`MEM_ADDR_BITS-1:0] idx;
		idx = req.adr[`MEM_ADDR_BITS-1:0];
		if (req.we) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (req.sel[lane]) begin
					shadow[idx][8*lane +: 8] = req.dat[8*lane +: 8];
				end
			end
		end
		return shadow[idx];
	endfunction

	function automatic wb_req_t make_req(input logic [29:0] adr, input logic [31:0] dat,
			input logic we, input logic [3:0] sel);
		wb_req_t req;
		req.adr = adr;
		req.dat = dat;
		req.we  = we;
		req.sel = sel;
		req.stb = 1'b0;
		return req;
	endfunction

	// mixes every address bit into the word
	function automatic logic [31:0] fill_word(input int idx);
		return (32'(idx) * 32'h0100_0193) ^ 32'h5aa5_0f0f;
	endfunction

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
		end
	endtask

	// one classic cycle started 1 ns after a rising edge
	// latency counts cycles from strobe to acknowledge
	task automatic bus_transfer(input bit is_data, input wb_req_t req,
			output logic [31:0] rdata, output int latency);
		wb_req_t cur;
		cur = req;
		cur.stb = 1'b1;
		latency = 0;
		if (is_data) begin
			data_req = cur;
		end else begin
			inst_req = cur;
		end
		@(negedge clk);
		while (!(is_data ? data_ack : inst_ack)) begin
			latency++;
			@(negedge clk);
		end
		rdata = rd_dat;
		@(posedge clk);
		#1;
		cur.stb = 1'b0;
		if (is_data) begin
			data_req = cur;
		end else begin
			inst_req = cur;
		end
	endtask

	// instruction port only fetches
	task automatic run_inst_master(input int count);
		logic [31:0] rdata;
		int          latency;
		for (int n = 0; n < count; n++) begin
			idle_cycles($urandom_range(3, 0));
			bus_transfer(1'b0, make_req(30'($urandom), 32'd0, 1'b0, 4'hf), rdata, latency);
		end
	endtask

	task automatic run_data_master(input int count);
		logic [31:0] rdata;
		int          latency;
		logic        we;
		logic [3:0]  sel;
		for (int n = 0; n < count; n++) begin
			we = 1'($urandom);
			sel = we ? 4'($urandom) : 4'hf;
			idle_cycles($urandom_range(3, 0));
			bus_transfer(1'b1, make_req(30'($urandom), $urandom, we, sel), rdata, latency);
		end
	endtask

	// ---------------------------
	// scoreboard
	// ---------------------------

	// acks are sampled mid cycle where they are stable
	initial begin
		forever begin
			@(negedge clk);
			if (!reset) begin
				check_value("inst_ack_o without strobe", 32'(inst_ack & ~inst_req.stb), 32'd0);
				check_value("data_ack_o without strobe", 32'(data_ack & ~data_req.stb), 32'd0);
				check_value("inst_ack_o with data_ack_o", 32'(inst_ack & data_ack), 32'd0);
				if (inst_ack && !inst_req.we) begin
					check_value("rd_dat_o on inst read", rd_dat, ref_access(inst_req));
				end else if (inst_ack) begin
					void'(ref_access(inst_req));
				end
				if (data_ack && !data_req.we) begin
					check_value("rd_dat_o on data read", rd_dat, ref_access(data_req));
				end else if (data_ack) begin
					void'(ref_access(data_req));
				end
			end
		end
	end

	// ---------------------------
	// test sequence
	// ---------------------------

	initial begin
		logic [29:0] addr;
		logic [31:0] wdat;
		logic [31:0] rdata;
		int          latency;
		logic [31:0] data_rd;
		logic [31:0] inst_rd;
		int          data_lat;
		int          inst_lat;
		reset = 1'b1;
		inst_req = '0;
		data_req = '0;
		void'($urandom(19708));
		repeat (2) begin
			@(posedge clk);
		end
		#1;
		reset = 1'b0;

		// quiet bus after reset
		repeat (4) begin
			@(negedge clk);
			check_value("inst_ack_o after reset", 32'(inst_ack), 32'd0);
			check_value("data_ack_o after reset", 32'(data_ack), 32'd0);
			check_value("rd_dat_o after reset", rd_dat, 32'd0);
		end
		@(posedge clk);
		#1;

		// lone write then read back
		addr = 30'($urandom);
		wdat = $urandom;
		bus_transfer(1'b1, make_req(addr, wdat, 1'b1, 4'hf), rdata, latency);
		check_value("data_ack_o write latency", 32'(latency), 32'(wait_cycles + 1));
		// a write leaves the read data alone
		check_value("rd_dat_o before first read", rdata, 32'd0);
		bus_transfer(1'b1, make_req(addr, 32'd0, 1'b0, 4'hf), rdata, latency);
		check_value("data_ack_o read latency", 32'(latency), 32'(wait_cycles + 1));
		check_value("rd_dat_o read back", rdata, wdat);

		// known contents everywhere
		for (int i = 0; i < mem_words; i++) begin
			bus_transfer(1'b1, make_req(30'(i), fill_word(i), 1'b1, 4'hf), rdata, latency);
		end

		// byte lanes, read back from either port
		for (int n = 0; n < byte_pairs; n++) begin
			addr = 30'($urandom);
			bus_transfer(1'b1, make_req(addr, $urandom, 1'b1, 4'($urandom)), rdata, latency);
			bus_transfer(1'($urandom), make_req(addr, 32'd0, 1'b0, 4'hf), rdata, latency);
		end

		// both strobe from idle, data goes first
		fork
			bus_transfer(1'b1, make_req(30'($urandom), 32'd0, 1'b0, 4'hf), data_rd, data_lat);
			bus_transfer(1'b0, make_req(30'($urandom), 32'd0, 1'b0, 4'hf), inst_rd, inst_lat);
		join
		check_value("data_ack_o before inst_ack_o", 32'(data_lat < inst_lat), 32'd1);
		check_value("data_ack_o shared latency", 32'(data_lat), 32'(wait_cycles + 1));
		check_value("inst_ack_o shared latency", 32'(inst_lat), 32'(2 * wait_cycles + 3));

		fork
			run_inst_master(mixed_per_port);
			run_data_master(mixed_per_port);
		join
		idle_cycles(4);

		if (UUT.u_arbiter.u_arb_props.assert_errors == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$display("%0d bus assertions failed", UUT.u_arbiter.u_arb_props.assert_errors);
			$fatal(1, "assertion failures during the run");
		end
	end

endmodule

// ==== source/bus_arbiter.sv ====
// ---------------------------
// bus arbiter
// two masters onto one wishbone classic bus, data port first
// ---------------------------

module bus_arbiter (
	input  logic                 clk,
	input  logic                 reset,

	// masters
	input  cpu_bus_pkg::wb_req_t inst_req_i,
	input  cpu_bus_pkg::wb_req_t data_req_i,
	output logic                 inst_ack_o,
	output logic                 data_ack_o,

	// shared bus
	output cpu_bus_pkg::wb_req_t bus_req_o,
	input  logic                 bus_ack_i
);

	import cpu_bus_pkg::*;

	arb_state_t arb_state;
	arb_state_t arb_state_next;

	// high while the data port owns the bus
	logic       sel_data;

	// strobe of the master that currently owns the bus
	logic       sel_stb;

	// ---------------------------
	// master selection
	// ---------------------------

	// idle follows the data strobe in the same cycle,
	// otherwise the held grant decides
	always_comb begin
		case (arb_state)
			ARB_DATA: sel_data = 1'b1;
			ARB_INST: sel_data = 1'b0;
			default:  sel_data = data_req_i.stb;
		endcase
	end

	assign sel_stb = sel_data ? data_req_i.stb : inst_req_i.stb;

	// ---------------------------
	// grant state
	// ---------------------------

	always_comb begin
		arb_state_next = arb_state;
		case (arb_state)
			ARB_IDLE: begin
				// data wins when both strobe
				if (data_req_i.stb) begin
					arb_state_next = ARB_DATA;
				end else if (inst_req_i.stb) begin
					arb_state_next = ARB_INST;
				end
			end
			ARB_INST, ARB_DATA: begin
				// release after the acknowledge, or if the master gave up
				if (bus_ack_i || !sel_stb) begin
					arb_state_next = ARB_IDLE;
				end
			end
			default: begin
				arb_state_next = ARB_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			arb_state <= ARB_IDLE;
		end else begin
			arb_state <= arb_state_next;
		end
	end

	// ---------------------------
	// request and acknowledge routing
	// ---------------------------

	// whole request struct is muxed, strobe included
	assign bus_req_o = sel_data ? data_req_i : inst_req_i;

	// only the owner sees the acknowledge
	assign inst_ack_o = bus_ack_i & ~sel_data;
	assign data_ack_o = bus_ack_i & sel_data;

endmodule

// ==== source/cpu_bus_defs.svh ====
// ---------------------------
// cpu bus settings
// memory depth and wait states
// ---------------------------

`ifndef CPU_BUS_DEFS_SVH
`define CPU_BUS_DEFS_SVH

// wait states added to every access, 0 to 15
// acknowledge comes BUS_WAIT_CYCLES+1 cycles after the strobe
`define BUS_WAIT_CYCLES 2

// ram holds 2**MEM_ADDR_BITS words of 32 bits
// only the low address bits select a word, the rest alias
`define MEM_ADDR_BITS 8

`endif

// ==== source/cpu_bus_pkg.sv ====
// ---------------------------
// cpu bus package
// request struct and arbiter state shared by the bus blocks
// ---------------------------

package cpu_bus_pkg;

	// ---------------------------
	// wishbone classic request
	// ---------------------------

	// one master's request, 68 bits
	// adr is the word address, byte bits 1:0 are not carried
	typedef struct packed {
		logic [29:0] adr;
		logic [31:0] dat;
		logic        we;
		// byte lanes, bit 0 is dat[7:0]
		logic [3:0]  sel;
		logic        stb;
	} wb_req_t;

	// ---------------------------
	// arbiter grant state
	// ---------------------------

	// idle means no grant held, the data strobe picks the master
	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,
		ARB_INST = 2'd1,
		ARB_DATA = 2'd2
	} arb_state_t;

endpackage

// ==== source/cpu_bus_top.sv ====
// ---------------------------
// cpu bus top
// arbiter, wait state timer and ram on one wishbone bus
// ---------------------------

module cpu_bus_top (
	input  logic                 clk,
	input  logic                 reset,

	// instruction and data ports
	input  cpu_bus_pkg::wb_req_t inst_req_i,
	input  cpu_bus_pkg::wb_req_t data_req_i,

	// shared read data, one ack per master
	output logic [31:0]          rd_dat_o,
	output logic                 inst_ack_o,
	output logic                 data_ack_o
);

	import cpu_bus_pkg::*;

	// granted request on the shared bus
	wb_req_t bus_req;

	// acknowledge from the timer, before routing
	logic    bus_ack;

	// ---------------------------
	// blocks
	// ---------------------------

	bus_arbiter u_arbiter (
		.clk        (clk),
		.reset      (reset),
		.inst_req_i (inst_req_i),
		.data_req_i (data_req_i),
		.inst_ack_o (inst_ack_o),
		.data_ack_o (data_ack_o),
		.bus_req_o  (bus_req),
		.bus_ack_i  (bus_ack)
	);

	// only the strobe matters to the timer
	wait_state_timer u_timer (
		.clk   (clk),
		.reset (reset),
		.stb_i (bus_req.stb),
		.ack_o (bus_ack)
	);

	// read data goes to both masters unchanged
	wb_ram u_ram (
		.clk       (clk),
		.reset     (reset),
		.bus_req_i (bus_req),
		.ack_i     (bus_ack),
		.rd_dat_o  (rd_dat_o)
	);

endmodule

// ==== source/wait_state_timer.sv ====
// ---------------------------
// wait state timer
// stretches each access and returns a one-cycle acknowledge
// ---------------------------

`include "cpu_bus_defs.svh"

module wait_state_timer (
	input  logic clk,
	input  logic reset,
	input  logic stb_i,
	output logic ack_o
);

	localparam logic [3:0] wait_load = 4'(`BUS_WAIT_CYCLES);

	// access in progress, count is valid
	logic       busy;

	// wait states still to go
	logic [3:0] count;

	// count as seen in this cycle, fresh load on cycle 0
	logic [3:0] count_now;

	assign count_now = busy ? count : wait_load;

	// ---------------------------
	// down counter and ack
	// ---------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= 4'd0;
			ack_o <= 1'b0;
		end else if (!stb_i) begin
			// strobe dropped, any count in flight is abandoned
			busy  <= 1'b0;
			count <= 4'd0;
			ack_o <= 1'b0;
		end else if (ack_o) begin
			// ack cycle done, a held strobe starts over next cycle
			busy  <= 1'b0;
			count <= 4'd0;
			ack_o <= 1'b0;
		end else if (count_now == 4'd0) begin
			// last wait state, ack in the next cycle
			busy  <= 1'b0;
			count <= 4'd0;
			ack_o <= 1'b1;
		end else begin
			busy  <= 1'b1;
			count <= count_now - 4'd1;
		end
	end

endmodule

// ==== source/wb_ram.sv ====
// ---------------------------
// wishbone ram
// word memory with byte lane writes and registered reads
// ---------------------------

`include "cpu_bus_defs.svh"

module wb_ram (
	input  logic                 clk,
	input  logic                 reset,
	input  cpu_bus_pkg::wb_req_t bus_req_i,
	input  logic                 ack_i,
	output logic [31:0]          rd_dat_o
);

	import cpu_bus_pkg::*;

	localparam int mem_words = 1 << `MEM_ADDR_BITS;

	logic [31:0]               mem [mem_words];
	logic [`MEM_ADDR_BITS-1:0] word_idx;
	logic                      wr_en;
	logic                      rd_en;

	// upper address bits are ignored
	assign word_idx = bus_req_i.adr[`MEM_ADDR_BITS-1:0];

	// write lands on the edge that ends the ack cycle
	assign wr_en = bus_req_i.stb & bus_req_i.we & ack_i;

	// read loads every wait cycle, last load is the edge before ack
	assign rd_en = bus_req_i.stb & ~bus_req_i.we & ~ack_i;

	// ---------------------------
	// write port
	// ---------------------------

	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (bus_req_i.sel[lane]) begin
					mem[word_idx][8*lane +: 8] <= bus_req_i.dat[8*lane +: 8];
				end
			end
		end
	end

	// ---------------------------
	// read port
	// ---------------------------

	// holds through the ack cycle and between reads
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_dat_o <= 32'd0;
		end else if (rd_en) begin
			rd_dat_o <= mem[word_idx];
		end
	end

endmodule

// ==== vlog.f ====
// headers
+incdir+source
// package first
source/cpu_bus_pkg.sv
// rtl
source/bus_arbiter.sv
source/wait_state_timer.sv
source/wb_ram.sv
source/cpu_bus_top.sv
// bench
bench/cpu_bus_properties.sv
bench/tb_cpu_bus_top.sv
